// ==== logic/body_rate_pkg.sv ====
`default_nettype none

package body_rate_pkg;

	// signed 12.4 fixed point, deg/s
	typedef logic signed [15:0] rate_t;

	// gyro rate straight from the imu
	// units are 1/100 deg/s
	typedef logic signed [15:0] imu_t;

	// products and running sums, wide enough for any gain times error
	typedef logic signed [31:0] wide_t;

	// one rate per body axis
	// used for targets, converted rates, errors and corrections
	typedef struct packed {
		rate_t roll;
		rate_t pitch;
		rate_t yaw;
	} axis_rate_t;

	// raw gyro sample, all three axes
	typedef struct packed {
		imu_t roll;
		imu_t pitch;
		imu_t yaw;
	} axis_imu_t;

	// angle loop error, 12.4 deg/s
	// yaw runs rate only, so no field for it
	typedef struct packed {
		rate_t roll;
		rate_t pitch;
	} angle_err_t;

	// unclamped pid sums before output limiting
	typedef struct packed {
		wide_t roll;
		wide_t pitch;
		wide_t yaw;
	} axis_wide_t;

	// 1/100 deg/s to 12.4 deg/s
	// 16/100 is approximated as 41/256
	localparam int imu_scale = 41;

	// right shift that goes with imu_scale
	localparam int imu_shift = 8;

endpackage

`default_nettype wire

// ==== logic/rate_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module rate_capture (
	input wire start_signal,
	input wire resetn,
	input wire cycle_start,
	input wire body_rate_pkg::axis_rate_t target,
	input wire body_rate_pkg::axis_imu_t gyro,
	input wire body_rate_pkg::angle_err_t angle_err,
	output logic cap_valid,
	output body_rate_pkg::axis_rate_t cap_target,
	output body_rate_pkg::axis_rate_t cap_actual,
	output body_rate_pkg::angle_err_t cap_angle
);

	// converted gyro rates, combinational
	body_rate_pkg::axis_rate_t actual_conv;

	// scale then shift, floor rounding from the arithmetic shift
	// full-scale gyro lands well inside rate_t after the shift
	function automatic body_rate_pkg::rate_t imu_to_rate(input body_rate_pkg::imu_t g);
		body_rate_pkg::wide_t scaled;
		scaled = body_rate_pkg::wide_t'(g) * body_rate_pkg::imu_scale;
		scaled = scaled >>> body_rate_pkg::imu_shift;
		return body_rate_pkg::rate_t'(scaled);
	endfunction

	// same rule on every axis
	always_comb begin
		actual_conv.roll = imu_to_rate(gyro.roll);
		actual_conv.pitch = imu_to_rate(gyro.pitch);
		actual_conv.yaw = imu_to_rate(gyro.yaw);
	end

	// valid bit follows the start pulse
	// one cycle late
	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			cap_valid <= 1'b0;
		end else begin
			cap_valid <= cycle_start;
		end
	end

	// sample registers
	// only load on a start, otherwise hold
	always_ff @(posedge start_signal) begin
		if (cycle_start) begin
			cap_target <= target;
			cap_actual <= actual_conv;
			cap_angle <= angle_err;
		end
	end

endmodule

`default_nettype wire

// ==== logic/rate_error.sv ====
`timescale 1ns/1ps
`default_nettype none

module rate_error (
	input wire start_signal,
	input wire resetn,
	input wire cap_valid,
	input wire body_rate_pkg::axis_rate_t cap_target,
	input wire body_rate_pkg::axis_rate_t cap_actual,
	input wire body_rate_pkg::angle_err_t cap_angle,
	output logic err_valid,
	output body_rate_pkg::axis_rate_t err
);

	// rate_t bounds at full width
	localparam body_rate_pkg::wide_t rate_max = 32767;
	localparam body_rate_pkg::wide_t rate_min = -32768;

	// full width errors before saturation
	body_rate_pkg::wide_t roll_wide;
	body_rate_pkg::wide_t pitch_wide;
	body_rate_pkg::wide_t yaw_wide;

	// pin to the rate_t range instead of wrapping
	function automatic body_rate_pkg::rate_t sat_rate(input body_rate_pkg::wide_t v);
		if (v > rate_max) return body_rate_pkg::rate_t'(rate_max);
		if (v < rate_min) return body_rate_pkg::rate_t'(rate_min);
		return body_rate_pkg::rate_t'(v);
	endfunction

	// target minus actual
	// roll and pitch also pick up the angle loop error
	always_comb begin
		roll_wide = body_rate_pkg::wide_t'(cap_target.roll) - body_rate_pkg::wide_t'(cap_actual.roll)
			+ body_rate_pkg::wide_t'(cap_angle.roll);
		pitch_wide = body_rate_pkg::wide_t'(cap_target.pitch)
			- body_rate_pkg::wide_t'(cap_actual.pitch) + body_rate_pkg::wide_t'(cap_angle.pitch);
		yaw_wide = body_rate_pkg::wide_t'(cap_target.yaw) - body_rate_pkg::wide_t'(cap_actual.yaw);
	end

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			err_valid <= 1'b0;
		end else begin
			err_valid <= cap_valid;
		end
	end

	// error registers, loaded with the sample they belong to
	always_ff @(posedge start_signal) begin
		if (cap_valid) begin
			err.roll <= sat_rate(roll_wide);
			err.pitch <= sat_rate(pitch_wide);
			err.yaw <= sat_rate(yaw_wide);
		end
	end

endmodule

`default_nettype wire

// ==== logic/pid_axis.sv ====
`timescale 1ns/1ps
`default_nettype none

module pid_axis #(
	// gains in signed 4.4
	parameter int kp = 24,
	parameter int ki = 2,
	parameter int kd = 8,
	// magnitude bound on the accumulated error
	parameter int integral_limit = 4000
) (
	input wire start_signal,
	input wire resetn,
	input wire err_valid,
	input wire body_rate_pkg::rate_t err,
	output logic pid_valid,
	output body_rate_pkg::wide_t pid_sum
);

	// axis state, carried from sample to sample
	body_rate_pkg::wide_t integral;
	body_rate_pkg::rate_t prev_err;

	// next-state and datapath terms
	body_rate_pkg::wide_t err_wide;
	body_rate_pkg::wide_t integral_raw;
	body_rate_pkg::wide_t integral_next;
	body_rate_pkg::wide_t p_term;
	body_rate_pkg::wide_t i_term;
	body_rate_pkg::wide_t d_term;
	body_rate_pkg::wide_t sum_next;

	always_comb begin
		err_wide = body_rate_pkg::wide_t'(err);

		// accumulate, then clamp both ways
		// anti-windup for long saturated stretches
		integral_raw = integral + err_wide;
		if (integral_raw > integral_limit) begin
			integral_next = integral_limit;
		end else if (integral_raw < -integral_limit) begin
			integral_next = -integral_limit;
		end else begin
			integral_next = integral_raw;
		end

		// i term uses the new integral, not the old one
		p_term = kp * err_wide;
		i_term = ki * integral_next;
		d_term = kd * (err_wide - body_rate_pkg::wide_t'(prev_err));

		// drop the 4 fraction bits of the gains, floor rounding
		sum_next = (p_term + i_term + d_term) >>> 4;
	end

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			pid_valid <= 1'b0;
		end else begin
			pid_valid <= err_valid;
		end
	end

	// state moves only on valid samples
	// back to back samples chain through it one per clock
	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			integral <= '0;
			prev_err <= '0;
		end else if (err_valid) begin
			integral <= integral_next;
			prev_err <= err;
		end
	end

	// unclamped result
	// limiting is done downstream
	always_ff @(posedge start_signal) begin
		if (err_valid) begin
			pid_sum <= sum_next;
		end
	end

endmodule

`default_nettype wire

// ==== logic/rate_limit.sv ====
`timescale 1ns/1ps
`default_nettype none

module rate_limit #(
	// mixer range, symmetric
	parameter int out_limit = 12000
) (
	input wire start_signal,
	input wire resetn,
	input wire pid_valid,
	input wire body_rate_pkg::axis_wide_t pid_sum,
	output body_rate_pkg::axis_rate_t rate_out,
	output logic complete_signal
);

	// clamped corrections, combinational
	body_rate_pkg::axis_rate_t limited;

	// clamp to +-out_limit and narrow to rate_t
	function automatic body_rate_pkg::rate_t clamp_out(input body_rate_pkg::wide_t v);
		if (v > out_limit) return body_rate_pkg::rate_t'(out_limit);
		if (v < -out_limit) return body_rate_pkg::rate_t'(-out_limit);
		return body_rate_pkg::rate_t'(v);
	endfunction

	always_comb begin
		limited.roll = clamp_out(pid_sum.roll);
		limited.pitch = clamp_out(pid_sum.pitch);
		limited.yaw = clamp_out(pid_sum.yaw);
	end

	// one cycle pulse per finished sample
	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			complete_signal <= 1'b0;
		end else begin
			complete_signal <= pid_valid;
		end
	end

	// output holds between completions, mixer may read it late
	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			rate_out <= '0;
		end else if (pid_valid) begin
			rate_out <= limited;
		end
	end

endmodule

`default_nettype wire

// ==== logic/body_frame_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module body_frame_controller #(
	// pid gains, signed 4.4
	parameter int kp = 24,
	parameter int ki = 2,
	parameter int kd = 8,
	parameter int integral_limit = 4000,
	parameter int out_limit = 12000
) (
	input wire start_signal,
	input wire resetn,
	input wire cycle_start,
	input wire body_rate_pkg::axis_rate_t target,
	input wire body_rate_pkg::axis_imu_t gyro,
	input wire body_rate_pkg::angle_err_t angle_err,
	output wire body_rate_pkg::axis_rate_t rate_out,
	output wire complete_signal
);

	// stage 1 to 2
	wire cap_valid;
	wire body_rate_pkg::axis_rate_t cap_target;
	wire body_rate_pkg::axis_rate_t cap_actual;
	wire body_rate_pkg::angle_err_t cap_angle;

	// stage 2 to 3
	wire err_valid;
	wire body_rate_pkg::axis_rate_t err;

	// stage 3 to 4
	// axes run in lockstep, roll valid stands for all three
	wire pid_valid;
	wire body_rate_pkg::axis_wide_t pid_sum;

	// capture and gyro unit conversion
	rate_capture rate_capture (
		.start_signal(start_signal),
		.resetn(resetn),
		.cycle_start(cycle_start),
		.target(target),
		.gyro(gyro),
		.angle_err(angle_err),
		.cap_valid(cap_valid),
		.cap_target(cap_target),
		.cap_actual(cap_actual),
		.cap_angle(cap_angle)
	);

	// saturated rate errors
	rate_error rate_error (
		.start_signal(start_signal),
		.resetn(resetn),
		.cap_valid(cap_valid),
		.cap_target(cap_target),
		.cap_actual(cap_actual),
		.cap_angle(cap_angle),
		.err_valid(err_valid),
		.err(err)
	);

	// one pid per axis, same gains on all
	pid_axis #(.kp(kp), .ki(ki), .kd(kd), .integral_limit(integral_limit)) roll_pid (
		.start_signal(start_signal),
		.resetn(resetn),
		.err_valid(err_valid),
		.err(err.roll),
		.pid_valid(pid_valid),
		.pid_sum(pid_sum.roll)
	);

	pid_axis #(.kp(kp), .ki(ki), .kd(kd), .integral_limit(integral_limit)) pitch_pid (
		.start_signal(start_signal),
		.resetn(resetn),
		.err_valid(err_valid),
		.err(err.pitch),
		.pid_valid(),
		.pid_sum(pid_sum.pitch)
	);

	pid_axis #(.kp(kp), .ki(ki), .kd(kd), .integral_limit(integral_limit)) yaw_pid (
		.start_signal(start_signal),
		.resetn(resetn),
		.err_valid(err_valid),
		.err(err.yaw),
		.pid_valid(),
		.pid_sum(pid_sum.yaw)
	);

	// clamp, hold and completion pulse
	rate_limit #(.out_limit(out_limit)) rate_limit (
		.start_signal(start_signal),
		.resetn(resetn),
		.pid_valid(pid_valid),
		.pid_sum(pid_sum),
		.rate_out(rate_out),
		.complete_signal(complete_signal)
	);

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	// 8 ns period
	parameter int half_period = 4,
	parameter int reset_cycles = 16
) (
	output logic start_signal,
	output logic resetn
);

	initial begin
		start_signal = 1'b0;
		forever #half_period start_signal = ~start_signal;
	end

	// release just after an edge, same as the other inputs
	initial begin
		resetn = 1'b0;
		repeat (reset_cycles) @(posedge start_signal);
		#1 resetn = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tests/tb_body_frame_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_body_frame_controller;

	// model copies of the default gains and limits
	localparam int kp = 24;
	localparam int ki = 2;
	localparam int kd = 8;
	localparam int integral_limit = 4000;
	localparam int out_limit = 12000;
	localparam int drive_delay = 1;
	localparam int wait_limit = 64;

	logic start_signal;
	logic resetn;
	logic cycle_start;
	body_rate_pkg::axis_rate_t target;
	body_rate_pkg::axis_imu_t gyro;
	body_rate_pkg::angle_err_t angle_err;
	body_rate_pkg::axis_rate_t rate_out;
	logic complete_signal;

	// random source and model state
	logic [31:0] lfsr_state;
	body_rate_pkg::wide_t model_integral [3];
	body_rate_pkg::rate_t model_prev [3];
	body_rate_pkg::axis_rate_t expected_q [$];
	body_rate_pkg::axis_rate_t head_value;
	body_rate_pkg::axis_rate_t last_out;

	string test_name;
	int checks_done;
	int value_errors;
	int other_errors;
	int pulse_count;
	int clamp_hits;

	tb_clock clk0 (
		.start_signal(start_signal),
		.resetn(resetn)
	);

	body_frame_controller dut0 (
		.start_signal(start_signal),
		.resetn(resetn),
		.cycle_start(cycle_start),
		.target(target),
		.gyro(gyro),
		.angle_err(angle_err),
		.rate_out(rate_out),
		.complete_signal(complete_signal)
	);

	// 32-bit galois step, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// n random bits, sign extended to 16
	function automatic body_rate_pkg::rate_t rand_signed(input int n);
		logic [31:0] v;
		v = rand_bits(n);
		if (n < 16 && v[n-1]) v = v | (32'hFFFFFFFF << n);
		return v[15:0];
	endfunction

	// hundredths of deg/s to 12.4, floor
	function automatic body_rate_pkg::rate_t gyro_to_fixed(input body_rate_pkg::imu_t g);
		body_rate_pkg::wide_t s;
		s = body_rate_pkg::wide_t'(g) * body_rate_pkg::imu_scale;
		s = s >>> body_rate_pkg::imu_shift;
		return s[15:0];
	endfunction

	function automatic body_rate_pkg::rate_t sat16(input body_rate_pkg::wide_t v);
		if (v > 32767) v = 32767;
		else if (v < -32768) v = -32768;
		return v[15:0];
	endfunction

	// one pid update, state carried per axis
	function automatic body_rate_pkg::wide_t pid_step(input int ax, input body_rate_pkg::rate_t e_in);
		body_rate_pkg::wide_t e;
		body_rate_pkg::wide_t acc;
		body_rate_pkg::wide_t sum;
		e = body_rate_pkg::wide_t'(e_in);
		acc = model_integral[ax] + e;
		if (acc > integral_limit) acc = integral_limit;
		else if (acc < -integral_limit) acc = -integral_limit;
		sum = kp * e + ki * acc + kd * (e - body_rate_pkg::wide_t'(model_prev[ax]));
		sum = sum >>> 4;
		model_integral[ax] = acc;
		model_prev[ax] = e_in;
		return sum;
	endfunction

	// settled pid output for a constant error, d term gone, integral pinned
	function automatic body_rate_pkg::rate_t settled_output(input body_rate_pkg::rate_t e,
		input int pinned);
		body_rate_pkg::wide_t s;
		s = (kp * body_rate_pkg::wide_t'(e) + ki * pinned) >>> 4;
		return s[15:0];
	endfunction

	// mixer range, counts how often it bites
	function automatic body_rate_pkg::rate_t clamp_mixer(input body_rate_pkg::wide_t v);
		if (v > out_limit) begin
			clamp_hits++;
			v = out_limit;
		end else if (v < -out_limit) begin
			clamp_hits++;
			v = -out_limit;
		end
		return v[15:0];
	endfunction

	task automatic model_push(input body_rate_pkg::axis_rate_t t, input body_rate_pkg::axis_imu_t g,
		input body_rate_pkg::angle_err_t a);
		body_rate_pkg::rate_t err_roll;
		body_rate_pkg::rate_t err_pitch;
		body_rate_pkg::rate_t err_yaw;
		body_rate_pkg::axis_rate_t exp_v;
		err_roll = sat16(body_rate_pkg::wide_t'(t.roll)
			- body_rate_pkg::wide_t'(gyro_to_fixed(g.roll)) + body_rate_pkg::wide_t'(a.roll));
		err_pitch = sat16(body_rate_pkg::wide_t'(t.pitch)
			- body_rate_pkg::wide_t'(gyro_to_fixed(g.pitch)) + body_rate_pkg::wide_t'(a.pitch));
		// no angle loop on yaw
		err_yaw = sat16(body_rate_pkg::wide_t'(t.yaw)
			- body_rate_pkg::wide_t'(gyro_to_fixed(g.yaw)));
		exp_v.roll = clamp_mixer(pid_step(0, err_roll));
		exp_v.pitch = clamp_mixer(pid_step(1, err_pitch));
		exp_v.yaw = clamp_mixer(pid_step(2, err_yaw));
		expected_q.push_back(exp_v);
	endtask

	task automatic next_cycle();
		@(posedge start_signal);
		#drive_delay;
	endtask

	// sample goes in at the coming edge
	task automatic drive_start(input body_rate_pkg::axis_rate_t t,
		input body_rate_pkg::axis_imu_t g, input body_rate_pkg::angle_err_t a);
		cycle_start = 1'b1;
		target = t;
		gyro = g;
		angle_err = a;
		model_push(t, g, a);
		next_cycle();
	endtask

	task automatic drive_idle(input int cycles);
		int n;
		cycle_start = 1'b0;
		for (n = 0; n < cycles; n++) next_cycle();
	endtask

	task automatic random_sample(input int bits, output body_rate_pkg::axis_rate_t t,
		output body_rate_pkg::axis_imu_t g, output body_rate_pkg::angle_err_t a);
		t.roll = rand_signed(bits);
		t.pitch = rand_signed(bits);
		t.yaw = rand_signed(bits);
		g.roll = rand_signed(bits);
		g.pitch = rand_signed(bits);
		g.yaw = rand_signed(bits);
		a.roll = rand_signed(bits);
		a.pitch = rand_signed(bits);
	endtask

	task automatic check_axis(input string axis_name, input body_rate_pkg::rate_t exp_v,
		input body_rate_pkg::rate_t act_v);
		checks_done++;
		assert (act_v == exp_v) else begin
			$display("error %s %s expected %0d actual %0d", test_name, axis_name, exp_v, act_v);
			value_errors++;
		end
	endtask

	// outputs must stay clear while reset is held
	task automatic wait_reset_release();
		int n;
		n = 0;
		@(posedge start_signal);
		while (resetn !== 1'b1 && n < wait_limit) begin
			@(negedge start_signal);
			assert (complete_signal == 1'b0 && rate_out == '0) else begin
				$display("complete_signal or rate_out not clear while resetn is low");
				other_errors++;
			end
			n++;
		end
		if (resetn !== 1'b1) begin
			$display("timeout, resetn was never released");
			other_errors++;
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (expected_q.size() != 0 && n < wait_limit) begin
			next_cycle();
			n++;
		end
		if (expected_q.size() != 0) begin
			$display("timeout in %s, %0d samples never completed", test_name, expected_q.size());
			other_errors++;
			expected_q.delete();
		end
	endtask

	// edges from sampling edge E to the first high complete_signal
	task automatic measure_latency();
		body_rate_pkg::axis_rate_t t;
		body_rate_pkg::axis_imu_t g;
		body_rate_pkg::angle_err_t a;
		int k;
		logic found;
		random_sample(16, t, g, a);
		drive_start(t, g, a);
		cycle_start = 1'b0;
		k = 0;
		found = 1'b0;
		while (!found && k < wait_limit) begin
			@(negedge start_signal);
			if (complete_signal) found = 1'b1;
			else k++;
		end
		if (!found) begin
			$display("timeout in %s, complete_signal never rose", test_name);
			other_errors++;
		end else begin
			checks_done++;
			assert (k == 3) else begin
				$display("error %s latency expected 3 actual %0d", test_name, k);
				value_errors++;
			end
		end
		wait_drain();
	endtask

	// scoreboard and hold check, sampled mid-cycle
	always @(negedge start_signal) begin
		if (resetn !== 1'b1) begin
			// rate_out sits at its reset value
			last_out = '0;
		end else if (complete_signal) begin
			if (expected_q.size() == 0) begin
				$display("complete_signal pulsed with no sample in flight during %s", test_name);
				other_errors++;
			end else begin
				head_value = expected_q.pop_front();
				check_axis("roll", head_value.roll, rate_out.roll);
				check_axis("pitch", head_value.pitch, rate_out.pitch);
				check_axis("yaw", head_value.yaw, rate_out.yaw);
			end
			pulse_count++;
			last_out = rate_out;
		end else begin
			assert (rate_out == last_out) else begin
				$display("rate_out changed without complete_signal during %s", test_name);
				other_errors++;
				last_out = rate_out;
			end
		end
	end

	initial begin
		body_rate_pkg::axis_rate_t t;
		body_rate_pkg::axis_imu_t g;
		body_rate_pkg::angle_err_t a;
		int base;
		int i;
		cycle_start = 1'b0;
		target = '0;
		gyro = '0;
		angle_err = '0;
		lfsr_state = 32'd43;
		last_out = '0;
		for (i = 0; i < 3; i++) begin
			model_integral[i] = '0;
			model_prev[i] = '0;
		end
		checks_done = 0;
		value_errors = 0;
		other_errors = 0;
		pulse_count = 0;
		clamp_hits = 0;

		test_name = "reset";
		wait_reset_release();
		drive_idle(3);

		test_name = "single_sample";
		for (i = 0; i < 3; i++) begin
			measure_latency();
			drive_idle(2);
		end

		// state chains through 40 samples in flight
		test_name = "back_to_back";
		base = pulse_count;
		for (i = 0; i < 40; i++) begin
			random_sample(12, t, g, a);
			drive_start(t, g, a);
		end
		drive_idle(0);
		wait_drain();
		drive_idle(4);
		checks_done++;
		assert (pulse_count - base == 40) else begin
			$display("error %s pulse count expected 40 actual %0d", test_name, pulse_count - base);
			value_errors++;
		end

		// steady error, yaw negative for the lower bound
		test_name = "integral_clamp";
		t.roll = 16'sd2000;
		t.pitch = 16'sd1500;
		t.yaw = -16'sd1800;
		g = '0;
		a = '0;
		for (i = 0; i < 24; i++) begin
			drive_start(t, g, a);
			drive_idle(1);
		end
		wait_drain();
		// last output held, integral pinned at the bound on every axis
		check_axis("roll", settled_output(t.roll, integral_limit), rate_out.roll);
		check_axis("pitch", settled_output(t.pitch, integral_limit), rate_out.pitch);
		check_axis("yaw", settled_output(t.yaw, -integral_limit), rate_out.yaw);

		// full range inputs, random idle gaps between starts
		test_name = "output_clamp";
		clamp_hits = 0;
		for (i = 0; i < 60; i++) begin
			random_sample(16, t, g, a);
			drive_start(t, g, a);
			drive_idle(rand_bits(2));
		end
		wait_drain();
		drive_idle(6);
		checks_done++;
		assert (clamp_hits > 0) else begin
			$display("no output reached the mixer limit in %s", test_name);
			other_errors++;
		end

		$display("checks %0d, value errors %0d, other errors %0d",
			checks_done, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/body_rate_pkg.sv
logic/rate_capture.sv
logic/rate_error.sv
logic/pid_axis.sv
logic/rate_limit.sv
logic/body_frame_controller.sv
tests/tb_clock.sv
tests/tb_body_frame_controller.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= tb_body_frame_controller
FILELIST ?= sources.f
OBJ_DIR ?= obj_dir
PASS_MSG = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only if the simulation printed the pass line
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
